//--- design/alu_pkg.sv
package alu_pkg;

  localparam int data_w = 64;

  typedef logic [data_w-1:0] data_t;

  typedef enum logic [3:0] {
    kind_add,
    kind_sub,
    kind_and,
    kind_or,
    kind_xor,
    kind_mov,
    kind_zxt,
    kind_sxt,
    kind_cmov,
    kind_cset
  } alu_kind_e;

  typedef enum logic [1:0] {
    size_16,
    size_32,
    size_64
  } alu_size_e;

  // flag conditions, same order as the jump comparator
  typedef enum logic [3:0] {
    z, nz, s, ns,
    ugt, ule, uge, ult,
    sgt, sle, sge, slt,
    o, no, p, np
  } cond_e;

  typedef struct packed {
    alu_kind_e kind;
    alu_size_e size;
    cond_e     cond;
    logic      sets_flags;
  } alu_op_t;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef struct packed {
    logic c4;  // raw carries out of the chain
    logic c16;
    logic c32;
    logic c64;
    logic v16; // signed overflow per width
    logic v32;
    logic v64;
  } add_status_t;

  // 16-bit writes keep the upper part of the destination
  function automatic data_t merge_width(input data_t res, input data_t a, input alu_size_e size);
    data_t m;
    case (size)
      size_16: m = {a[63:16], res[15:0]};
      size_32: m = {32'b0, res[31:0]};
      default: m = res;
    endcase
    return m;
  endfunction

endpackage

//--- design/alu_adder.sv
`timescale 1ns/100ps

module alu_adder (
  input  alu_pkg::data_t       a,
  input  alu_pkg::data_t       b,
  input  logic                 sub,
  output alu_pkg::data_t       sum,
  output alu_pkg::add_status_t status
);
  import alu_pkg::*;

  data_t       bx;
  logic [4:0]  s0;
  logic [12:0] s1;
  logic [16:0] s2;
  logic [32:0] s3;

  assign bx = sub ? ~b : b; // a - b as a + ~b + 1

  // one chain, split where the carries are tapped
  assign s0 = {1'b0, a[3:0]} + {1'b0, bx[3:0]} + {4'b0, sub};
  assign s1 = {1'b0, a[15:4]} + {1'b0, bx[15:4]} + {12'b0, s0[4]};
  assign s2 = {1'b0, a[31:16]} + {1'b0, bx[31:16]} + {16'b0, s1[12]};
  assign s3 = {1'b0, a[63:32]} + {1'b0, bx[63:32]} + {32'b0, s2[16]};

  assign sum = {s3[31:0], s2[15:0], s1[11:0], s0[3:0]};

  assign status.c4  = s0[4];
  assign status.c16 = s1[12];
  assign status.c32 = s2[16];
  assign status.c64 = s3[32];

  // same operand signs, result sign differs
  assign status.v16 = (a[15] == bx[15]) && (sum[15] != a[15]);
  assign status.v32 = (a[31] == bx[31]) && (sum[31] != a[31]);
  assign status.v64 = (a[63] == bx[63]) && (sum[63] != a[63]);

endmodule

//--- design/alu_cond_eval.sv
`timescale 1ns/100ps

module alu_cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_e  cond,
  output logic            taken
);
  import alu_pkg::*;

  logic sxo;

  assign sxo = flags.s ^ flags.o; // signed less than

  always_comb begin
    case (cond)
      z:       taken = flags.z;
      nz:      taken = ~flags.z;
      s:       taken = flags.s;
      ns:      taken = ~flags.s;
      ugt:     taken = ~(flags.c | flags.z);
      ule:     taken = flags.c | flags.z;
      uge:     taken = ~flags.c;
      ult:     taken = flags.c;
      sgt:     taken = ~(sxo | flags.z);
      sle:     taken = sxo | flags.z;
      sge:     taken = ~sxo;
      slt:     taken = sxo;
      o:       taken = flags.o;
      no:      taken = ~flags.o;
      p:       taken = flags.p;
      default: taken = ~flags.p; // np
    endcase
  end

endmodule

//--- design/alu_logic_move.sv
`timescale 1ns/100ps

module alu_logic_move (
  input  alu_pkg::alu_op_t op,
  input  alu_pkg::data_t   a,
  input  alu_pkg::data_t   b,
  input  logic             taken,
  output alu_pkg::data_t   res
);
  import alu_pkg::*;

  data_t zxt_val;
  data_t sxt_val;

  // extension source width comes from size
  always_comb begin
    case (op.size)
      size_16: begin
        zxt_val = {48'b0, b[15:0]};
        sxt_val = {{48{b[15]}}, b[15:0]};
      end
      size_32: begin
        zxt_val = {32'b0, b[31:0]};
        sxt_val = {{32{b[31]}}, b[31:0]};
      end
      default: begin
        zxt_val = b;
        sxt_val = b;
      end
    endcase
  end

  always_comb begin
    case (op.kind)
      kind_and:  res = merge_width(a & b, a, op.size);
      kind_or:   res = merge_width(a | b, a, op.size);
      kind_xor:  res = merge_width(a ^ b, a, op.size);
      kind_mov:  res = merge_width(b, a, op.size);
      kind_zxt:  res = zxt_val;
      kind_sxt:  res = sxt_val;
      kind_cmov: res = merge_width(taken ? b : a, a, op.size);
      kind_cset: res = {63'b0, taken}; // full width, no merge
      default:   res = '0; // arithmetic goes through the adder
    endcase
  end

endmodule

//--- design/alu_result_stage.sv
`timescale 1ns/100ps

module alu_result_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 en,
  input  alu_pkg::alu_op_t     op,
  input  alu_pkg::data_t       a,
  input  alu_pkg::data_t       sum,
  input  alu_pkg::add_status_t add_status,
  input  alu_pkg::data_t       move_res,
  output logic                 res_valid,
  output alu_pkg::data_t       res,
  output alu_pkg::flags_t      flags,
  output logic                 flags_valid
);
  import alu_pkg::*;

  data_t       sel_res;
  data_t       res_q;
  alu_op_t     op_q;
  add_status_t status_q;
  logic        valid_q;
  logic        arith_q;
  logic        logic_q;
  logic        sub_q;
  logic        sign_w;
  logic        zero_w;
  logic        carry_w;
  logic        ovf_w;
  logic        parity;

  assign sel_res = (op.kind == kind_add || op.kind == kind_sub) ?
                   merge_width(sum, a, op.size) : move_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= 1'b0;
      res_q    <= '0;
      op_q     <= '0;
      status_q <= '0;
    end else begin
      valid_q  <= en;
      res_q    <= sel_res;
      op_q     <= op;
      status_q <= add_status;
    end
  end

  assign arith_q = (op_q.kind == kind_add) || (op_q.kind == kind_sub);
  assign logic_q = (op_q.kind == kind_and) || (op_q.kind == kind_or) ||
                   (op_q.kind == kind_xor);
  assign sub_q   = (op_q.kind == kind_sub); // borrow is inverted carry
  assign parity  = ~^res_q[7:0];            // low byte only

  // pick flags at the operation width
  always_comb begin
    case (op_q.size)
      size_16: begin
        sign_w  = res_q[15];
        zero_w  = (res_q[15:0] == 16'b0);
        carry_w = status_q.c16;
        ovf_w   = status_q.v16;
      end
      size_32: begin
        sign_w  = res_q[31];
        zero_w  = (res_q[31:0] == 32'b0);
        carry_w = status_q.c32;
        ovf_w   = status_q.v32;
      end
      default: begin
        sign_w  = res_q[63];
        zero_w  = (res_q == '0);
        carry_w = status_q.c64;
        ovf_w   = status_q.v64;
      end
    endcase
  end

  always_comb begin
    if (valid_q && arith_q)
      flags = '{c: carry_w ^ sub_q, o: ovf_w, a: status_q.c4 ^ sub_q,
                s: sign_w, z: zero_w, p: parity};
    else if (valid_q && logic_q)
      flags = '{c: 1'b0, o: 1'b0, a: 1'b0, s: sign_w, z: zero_w, p: parity};
    else
      flags = '0; // moves and idle cycles
  end

  assign res_valid   = valid_q;
  assign res         = res_q;
  assign flags_valid = valid_q && op_q.sets_flags && (arith_q || logic_q);

endmodule

//--- design/alu_top.sv
`timescale 1ns/100ps

module alu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  alu_pkg::alu_op_t op,
  input  alu_pkg::data_t   a,
  input  alu_pkg::data_t   b,
  input  alu_pkg::flags_t  flags_in,
  output logic             res_valid,
  output alu_pkg::data_t   res,
  output alu_pkg::flags_t  flags,
  output logic             flags_valid
);
  import alu_pkg::*;

  data_t       sum;
  add_status_t add_status;
  data_t       move_res;
  logic        taken;
  logic        sub;

  assign sub = (op.kind == kind_sub);

  alu_adder u_adder (
    .a      (a),
    .b      (b),
    .sub    (sub),
    .sum    (sum),
    .status (add_status)
  );

  // condition checked against the current architectural flags
  alu_cond_eval u_cond (.flags(flags_in), .cond(op.cond), .taken(taken));

  alu_logic_move u_logic (.op(op), .a(a), .b(b), .taken(taken), .res(move_res));

  alu_result_stage u_result (
    .clk(clk), .rst(rst), .en(en), .op(op), .a(a),
    .sum(sum), .add_status(add_status), .move_res(move_res),
    .res_valid(res_valid), .res(res), .flags(flags), .flags_valid(flags_valid)
  );

endmodule

//--- bench/alu_properties.sv
`timescale 1ns/100ps

module alu_properties (
  input logic clk,
  input logic rst,
  input logic en,
  input logic res_valid,
  input logic flags_valid
);

  int assert_errors = 0;

  flags_need_result: assert property (@(posedge clk) disable iff (rst)
    flags_valid |-> res_valid)
    else begin
      $error("flags_valid high without res_valid");
      assert_errors++;
    end

  // one register between en and res_valid
  valid_follows_en: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> res_valid == $past(en))
    else begin
      $error("res_valid does not match en of the previous cycle");
      assert_errors++;
    end

  quiet_in_reset: assert property (@(posedge clk) rst |=> !res_valid)
    else begin
      $error("res_valid high after a reset cycle");
      assert_errors++;
    end

endmodule

bind alu_top alu_properties u_props (
  .clk(clk), .rst(rst), .en(en), .res_valid(res_valid), .flags_valid(flags_valid)
);

//--- bench/alu_tb.sv
`timescale 1ns/100ps

module alu_tb;
  import alu_pkg::*;

  typedef struct packed {
    alu_op_t op;
    data_t   a;
    data_t   b;
    flags_t  fin;
    data_t   res;
    flags_t  flags;
    logic    fv;
  } vector_t;

  localparam int reset_cycles = 16;
  localparam int random_count = 40;

  logic    clk;
  logic    rst;
  logic    en;
  alu_op_t op;
  data_t   a;
  data_t   b;
  flags_t  flags_in;
  logic    res_valid;
  data_t   res;
  flags_t  flags;
  logic    flags_valid;

  vector_t vectors[$];
  int      errors;
  int      test_errors;
  int      tests;
  int      cycles;
  int      cycle_limit;
  int      table_size;

  alu_top dut (
    .clk(clk), .rst(rst), .en(en), .op(op), .a(a), .b(b), .flags_in(flags_in),
    .res_valid(res_valid), .res(res), .flags(flags), .flags_valid(flags_valid)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: no end of run after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t %s: expected %h, got %h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    $display("%-12s %0d mismatches", name, test_errors);
    tests++;
    test_errors = 0;
  endtask

  function automatic vector_t make_vector(alu_kind_e kind, alu_size_e size, data_t a_val,
                                          data_t b_val, data_t res_val, flags_t flags_val);
    vector_t v;
    v = '0;
    v.op.kind = kind;
    v.op.size = size;
    v.op.cond = z; // ignored outside cmov/cset
    v.op.sets_flags = 1'b1;
    v.a = a_val;
    v.b = b_val;
    v.res = res_val;
    v.flags = flags_val;
    v.fv = (kind inside {kind_add, kind_sub, kind_and, kind_or, kind_xor});
    return v;
  endfunction

  task automatic add_vector(alu_kind_e kind, alu_size_e size, data_t a_val, data_t b_val,
                            data_t res_val, flags_t flags_val);
    vectors.push_back(make_vector(kind, size, a_val, b_val, res_val, flags_val));
  endtask

  // a and b fixed so the result shows which operand was picked
  task automatic add_cond_vector(alu_kind_e kind, alu_size_e size, cond_e cond,
                                 flags_t fin, data_t res_val);
    vector_t v;
    v = make_vector(kind, size, 64'h1111_1111_1111_1111, 64'h2222_2222_2222_2222,
                    res_val, 6'b0);
    v.op.cond = cond;
    v.fin = fin;
    vectors.push_back(v);
  endtask

  function automatic vector_t random_vector();
    vector_t v;
    data_t   r;
    int      sel;
    sel = $urandom % 3;
    v = make_vector(($urandom % 2) ? kind_xor : kind_and,
                    (sel == 0) ? size_16 : (sel == 1) ? size_32 : size_64,
                    {$urandom, $urandom}, {$urandom, $urandom}, 64'h0, 6'b0);
    if ($urandom % 4 == 0)
      v.b = v.a; // zero result for xor
    r = (v.op.kind == kind_xor) ? (v.a ^ v.b) : (v.a & v.b);
    case (v.op.size)
      size_16: begin
        v.res = {v.a[63:16], r[15:0]};
        v.flags.s = r[15];
        v.flags.z = (r[15:0] == 16'h0);
      end
      size_32: begin
        v.res = {32'h0, r[31:0]};
        v.flags.s = r[31];
        v.flags.z = (r[31:0] == 32'h0);
      end
      default: begin
        v.res = r;
        v.flags.s = r[63];
        v.flags.z = (r == 64'h0);
      end
    endcase
    v.flags.p = ~^r[7:0];
    return v;
  endfunction

  task automatic drive_vector(vector_t v);
    en <= 1'b1;
    op <= v.op;
    a <= v.a;
    b <= v.b;
    flags_in <= v.fin;
  endtask

  task automatic check_vector(vector_t v);
    check_value("res_valid", 64'h1, 64'(res_valid));
    check_value("res", v.res, res);
    check_value("flags", 64'(v.flags), 64'(flags));
    check_value("flags_valid", 64'(v.fv), 64'(flags_valid));
  endtask

  // issue back to back, each result checked one cycle after its en
  task automatic run_stream(int first, int last);
    for (int i = first; i <= last; i++) begin
      @(posedge clk);
      drive_vector(vectors[i]);
      if (i > first) begin
        @(negedge clk);
        check_vector(vectors[i-1]);
      end
    end
    @(posedge clk);
    en <= 1'b0;
    @(negedge clk);
    check_vector(vectors[last]);
    @(negedge clk);
    check_value("res_valid", 64'h0, 64'(res_valid));
  endtask

  initial begin
    vector_t v;
    void'($urandom(32'h43b34105));
    rst = 1'b1;
    en = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    flags_in = '0;
    errors = 0;
    test_errors = 0;
    tests = 0;
    cycles = 0;

    // flags column order c o a s z p
    add_vector(kind_add, size_64, 64'h7fffffffffffffff, 64'h1, 64'h8000000000000000, 6'b011101);
    add_vector(kind_add, size_64, 64'hffffffffffffffff, 64'h1, 64'h0, 6'b101011);
    add_vector(kind_sub, size_64, 64'h8000000000000000, 64'h1, 64'h7fffffffffffffff, 6'b011001);
    add_vector(kind_sub, size_64, 64'h5, 64'h7, 64'hfffffffffffffffe, 6'b101100);
    add_vector(kind_add, size_32, 64'hdeadbeef7fffffff, 64'h1, 64'h0000000080000000, 6'b011101);
    add_vector(kind_add, size_32, 64'h00000001ffffffff, 64'h2, 64'h1, 6'b101000);
    add_vector(kind_sub, size_32, 64'hffffffff00000000, 64'h1, 64'h00000000ffffffff, 6'b101101);
    add_vector(kind_add, size_16, 64'h1122334455667fff, 64'h1, 64'h1122334455668000, 6'b011101);
    add_vector(kind_sub, size_16, 64'haaaabbbbcccc8000, 64'h1, 64'haaaabbbbcccc7fff, 6'b011001);
    add_vector(kind_add, size_16, 64'h0123456789abffff, 64'h1, 64'h0123456789ab0000, 6'b101011);
    v = make_vector(kind_add, size_64, 64'h3, 64'h4, 64'h7, 6'b0);
    v.op.sets_flags = 1'b0;
    v.fv = 1'b0;
    vectors.push_back(v);
    add_vector(kind_and, size_64, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
               64'hf000_f000_f000_f000, 6'b000101);
    add_vector(kind_or, size_32, 64'hffff_ffff_0000_0001, 64'h0000_0000_8000_0002,
               64'h0000_0000_8000_0003, 6'b000101);
    add_vector(kind_xor, size_32, 64'h1234_5678_abcd_ef01, 64'h8765_4321_abcd_ef01,
               64'h0, 6'b000011);
    add_vector(kind_xor, size_16, 64'hcafe0000000000ff, 64'hf, 64'hcafe0000000000f0, 6'b000001);
    add_vector(kind_mov, size_32, 64'hffff_ffff_ffff_ffff, 64'h1234_5678_9abc_def0,
               64'h0000_0000_9abc_def0, 6'b0);
    add_vector(kind_zxt, size_16, 64'h0, 64'hffffffffffff8001, 64'h0000000000008001, 6'b0);
    add_vector(kind_zxt, size_16, 64'h0, 64'hffffffffffff7001, 64'h0000000000007001, 6'b0);
    add_vector(kind_sxt, size_16, 64'h0, 64'hffffffffffff8001, 64'hffffffffffff8001, 6'b0);
    add_vector(kind_sxt, size_16, 64'h0, 64'hffffffffffff7001, 64'h0000000000007001, 6'b0);
    add_vector(kind_zxt, size_32, 64'h0, 64'h1234567887654321, 64'h0000000087654321, 6'b0);
    add_vector(kind_zxt, size_32, 64'h0, 64'hffffffff12345678, 64'h0000000012345678, 6'b0);
    add_vector(kind_sxt, size_32, 64'h0, 64'h1234567887654321, 64'hffffffff87654321, 6'b0);
    add_vector(kind_sxt, size_32, 64'h0, 64'hffffffff12345678, 64'h0000000012345678, 6'b0);
    add_cond_vector(kind_cmov, size_64, z, 6'b000010, 64'h2222222222222222);
    add_cond_vector(kind_cmov, size_64, z, 6'b000000, 64'h1111111111111111);
    add_cond_vector(kind_cmov, size_64, ugt, 6'b000000, 64'h2222222222222222);
    add_cond_vector(kind_cmov, size_64, ugt, 6'b100000, 64'h1111111111111111);
    add_cond_vector(kind_cmov, size_32, sge, 6'b010100, 64'h0000000022222222);
    add_cond_vector(kind_cmov, size_32, sge, 6'b000100, 64'h0000000011111111);
    add_cond_vector(kind_cset, size_64, sgt, 6'b000000, 64'h1);
    add_cond_vector(kind_cset, size_64, sgt, 6'b000010, 64'h0);
    add_cond_vector(kind_cset, size_64, p, 6'b000001, 64'h1);
    add_cond_vector(kind_cset, size_64, p, 6'b000000, 64'h0);
    table_size = vectors.size();
    cycle_limit = reset_cycles + 2 * table_size + random_count + 50;

    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("res", 64'h0, res);
    check_value("flags", 64'h0, 64'(flags));
    repeat (3) begin
      check_value("res_valid", 64'h0, 64'(res_valid));
      check_value("flags_valid", 64'h0, 64'(flags_valid));
      @(negedge clk);
    end
    finish_test("reset");

    run_stream(0, table_size - 1);
    finish_test("back_to_back");

    for (int i = 0; i < table_size; i++) begin
      @(posedge clk);
      drive_vector(vectors[i]);
      @(posedge clk);
      en <= 1'b0; // idle cycle between entries
      @(negedge clk);
      check_vector(vectors[i]);
    end
    finish_test("idle_gap");

    repeat (random_count) vectors.push_back(random_vector());
    run_stream(table_size, vectors.size() - 1);
    finish_test("random");

    $display("summary: %0d tests, %0d value errors, %0d assertion errors",
             tests, errors, dut.u_props.assert_errors);
    if (errors == 0 && dut.u_props.assert_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
design/alu_pkg.sv
design/alu_adder.sv
design/alu_cond_eval.sv
design/alu_logic_move.sv
design/alu_result_stage.sv
design/alu_top.sv
bench/alu_properties.sv
bench/alu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = alu_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
